// File: src/barrierPkg.sv
`default_nettype none

package barrierPkg;

    ////////////////////
    // Geometry
    ////////////////////

    // Screen coordinate width
    localparam int coordWidth = 11;

    // Barriers in the row above the player
    localparam int numBarriers = 4;

    // Blocks per barrier side, both columns and rows
    localparam int blocksPerSide = 4;

    ////////////////////
    // Health and colour
    ////////////////////

    localparam int healthWidth = 3;

    // Starting health of a solid block
    localparam int fullHealth = 3;

    // Fixed low colour bits under the health field
    localparam logic [3:0] barrierTint = 4'b1000;

    ////////////////////
    // Types
    ////////////////////

    typedef logic [coordWidth-1:0] coordT;

    // One screen point
    typedef struct packed {
        coordT x;
        coordT y;
    } screenPointT;

    // Block address inside the barrier row
    typedef struct packed {
        logic [1:0] barrier;
        logic [1:0] col;
        logic [1:0] row;
    } blockAddrT;

    typedef logic [healthWidth-1:0] healthT;

    // Zero top bit, health, then tint
    typedef logic [7:0] colorT;

    // Locator result
    typedef struct packed {
        logic      inBarrier;
        blockAddrT addr;
    } locatedT;

    // Side-band tag on the pixel path
    typedef struct packed {
        logic lastInLine;
    } pixelTagT;

endpackage

`default_nettype wire

// File: src/barrierLocator.sv
`timescale 1ns/1ns
`default_nettype none

module barrierLocator #(
    parameter type payloadT     = logic,
    parameter int  blockSize    = 8,
    parameter int  barrierLeftX = 96,
    parameter int  barrierTopY  = 400,
    parameter int  barrierPitch = 128
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    // Request side
    input  wire logic                   inValid,
    output logic                        inReady,
    input  wire barrierPkg::screenPointT point,
    input  wire payloadT                payloadIn,
    // Result side
    output logic                        outValid,
    input  wire logic                   outReady,
    output barrierPkg::locatedT         located,
    output payloadT                     payloadOut
);

    // Shift amounts, both sizes are powers of two
    localparam int blockShift   = $clog2(blockSize);
    localparam int pitchShift   = $clog2(barrierPitch);
    // Barrier width and height in pixels
    localparam int barrierWidth = barrierPkg::blocksPerSide * blockSize;

    barrierPkg::coordT   dx;
    barrierPkg::coordT   dy;
    barrierPkg::coordT   remX;
    barrierPkg::coordT   barrierIdx;
    barrierPkg::coordT   colWide;
    barrierPkg::coordT   rowWide;
    logic                insideX;
    logic                insideY;
    barrierPkg::locatedT locatedNext;

    ////////////////////
    // Locate
    ////////////////////

    // Offsets from the barrier row origin
    assign dx = point.x - barrierPkg::coordT'(barrierLeftX);
    assign dy = point.y - barrierPkg::coordT'(barrierTopY);

    // Divide by pitch, keep quotient and remainder
    assign barrierIdx = dx >> pitchShift;
    assign remX       = dx & barrierPkg::coordT'(barrierPitch - 1);

    // Left of the first barrier wraps dx, so test x directly
    assign insideX = (point.x >= barrierPkg::coordT'(barrierLeftX))
                  && (barrierIdx < barrierPkg::coordT'(barrierPkg::numBarriers))
                  && (remX < barrierPkg::coordT'(barrierWidth));

    assign insideY = (point.y >= barrierPkg::coordT'(barrierTopY))
                  && (dy < barrierPkg::coordT'(barrierWidth));

    // Block indices inside the barrier
    assign colWide = remX >> blockShift;
    assign rowWide = dy >> blockShift;

    always_comb begin
        locatedNext.inBarrier   = insideX && insideY;
        locatedNext.addr.barrier = barrierIdx[1:0];
        locatedNext.addr.col     = colWide[1:0];
        locatedNext.addr.row     = rowWide[1:0];
    end

    ////////////////////
    // Output register
    ////////////////////

    // Free when empty or draining this cycle
    assign inReady = !outValid || outReady;

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    // Payload loads only on a transfer
    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            located    <= locatedNext;
            payloadOut <= payloadIn;
        end
    end

endmodule

`default_nettype wire

// File: src/barrierHealthStore.sv
`timescale 1ns/1ns
`default_nettype none

module barrierHealthStore (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 restart,
    // Laser damage requests
    input  wire logic                 damageValid,
    output logic                      damageReady,
    input  wire barrierPkg::locatedT  damageAddr,
    // Result pulses
    output logic                      laserHit,
    output logic                      laserMiss,
    // Display read port
    input  wire barrierPkg::blockAddrT readAddr,
    output barrierPkg::healthT        readHealth
);

    localparam int sideLast = barrierPkg::blocksPerSide - 1;

    // Health per barrier, column and row
    barrierPkg::healthT health [barrierPkg::numBarriers]
                               [barrierPkg::blocksPerSide]
                               [barrierPkg::blocksPerSide];

    barrierPkg::healthT targetHealth;
    logic               damageFire;

    // Arch pattern of a fresh barrier
    function automatic barrierPkg::healthT startHealth(input int col, input int row);
        logic outerCol;
        outerCol = (col == 0) || (col == sideLast);
        if (outerCol) begin
            // Outer legs lose only the bottom row
            return (row == sideLast) ? '0 : barrierPkg::healthT'(barrierPkg::fullHealth);
        end
        // Inner columns open the two bottom rows
        return (row >= sideLast - 1) ? '0 : barrierPkg::healthT'(barrierPkg::fullHealth);
    endfunction

    ////////////////////
    // Damage handshake
    ////////////////////

    // No damage taken while restoring
    assign damageReady = !restart;
    assign damageFire  = damageValid && damageReady;

    // Health of the block the laser points at
    assign targetHealth = health[damageAddr.addr.barrier]
                                [damageAddr.addr.col]
                                [damageAddr.addr.row];

    ////////////////////
    // Health array
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset || restart) begin
            for (int b = 0; b < barrierPkg::numBarriers; b++) begin
                for (int c = 0; c < barrierPkg::blocksPerSide; c++) begin
                    for (int r = 0; r < barrierPkg::blocksPerSide; r++) begin
                        health[b][c][r] <= startHealth(c, r);
                    end
                end
            end
        end else if (damageFire && damageAddr.inBarrier && targetHealth != '0) begin
            // One point off a living block
            health[damageAddr.addr.barrier]
                  [damageAddr.addr.col]
                  [damageAddr.addr.row] <= targetHealth - 1'b1;
        end
    end

    // Hit or miss pulse, one per accepted laser
    always_ff @(posedge clk) begin
        if (reset) begin
            laserHit  <= 1'b0;
            laserMiss <= 1'b0;
        end else begin
            laserHit  <= damageFire && damageAddr.inBarrier && targetHealth != '0;
            laserMiss <= damageFire && !(damageAddr.inBarrier && targetHealth != '0);
        end
    end

    ////////////////////
    // Display read
    ////////////////////

    // Combinational, sees every earlier edge's damage
    assign readHealth = health[readAddr.barrier][readAddr.col][readAddr.row];

endmodule

`default_nettype wire

// File: src/barrierPixelStage.sv
`timescale 1ns/1ns
`default_nettype none

module barrierPixelStage (
    input  wire logic                  clk,
    input  wire logic                  reset,
    // Located pixels from the locator
    input  wire logic                  inValid,
    output logic                       inReady,
    input  wire barrierPkg::locatedT   located,
    input  wire barrierPkg::pixelTagT  tag,
    // Health store read port
    output barrierPkg::blockAddrT      readAddr,
    input  wire barrierPkg::healthT    readHealth,
    // Pixel result
    output logic                       outValid,
    input  wire logic                  outReady,
    output logic                       isBarrier,
    output barrierPkg::colorT          rgb,
    output logic                       last
);

    logic              alive;
    barrierPkg::colorT rgbNext;

    ////////////////////
    // Lookup
    ////////////////////

    // Read straight from the located block
    assign readAddr = located.addr;

    // Drawn only inside a barrier with health left
    assign alive = located.inBarrier && (readHealth != '0);

    // Brightness follows health
    always_comb begin
        if (alive) begin
            rgbNext = {1'b0, readHealth, barrierPkg::barrierTint};
        end else begin
            rgbNext = '0;
        end
    end

    ////////////////////
    // Output register
    ////////////////////

    assign inReady = !outValid || outReady;

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    // Result and tag held until taken
    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            isBarrier <= alive;
            rgb       <= rgbNext;
            last      <= tag.lastInLine;
        end
    end

endmodule

`default_nettype wire

// File: src/barrierDisplayTop.sv
`timescale 1ns/1ns
`default_nettype none

module barrierDisplayTop #(
    parameter int blockSize    = 8,
    parameter int barrierLeftX = 96,
    parameter int barrierTopY  = 400,
    parameter int barrierPitch = 128
) (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    restart,
    // Pixel request
    input  wire logic                    pixelInValid,
    output logic                         pixelInReady,
    input  wire barrierPkg::screenPointT pixelIn,
    input  wire logic                    pixelInLast,
    // Pixel result
    output logic                         pixelOutValid,
    input  wire logic                    pixelOutReady,
    output logic                         isBarrier,
    output barrierPkg::colorT            rgb,
    output logic                         pixelOutLast,
    // Laser request
    input  wire logic                    laserValid,
    output logic                         laserReady,
    input  wire barrierPkg::screenPointT laser,
    // Laser result
    output logic                         laserHit,
    output logic                         laserMiss,
    output barrierPkg::screenPointT      laserHitPoint
);

    // Pixel path between the stages
    barrierPkg::pixelTagT  pixelTagIn;
    barrierPkg::pixelTagT  pixelTagLoc;
    barrierPkg::locatedT   pixelLocated;
    logic                  pixelLocValid;
    logic                  pixelLocReady;
    barrierPkg::blockAddrT readAddr;
    barrierPkg::healthT    readHealth;

    // Laser path into the store
    barrierPkg::locatedT   laserLocated;
    logic                  laserLocValid;
    logic                  laserLocReady;

    assign pixelTagIn.lastInLine = pixelInLast;

    ////////////////////
    // Pixel path
    ////////////////////

    barrierLocator #(
        .payloadT    (barrierPkg::pixelTagT),
        .blockSize   (blockSize),
        .barrierLeftX(barrierLeftX),
        .barrierTopY (barrierTopY),
        .barrierPitch(barrierPitch)
    ) pixelLocator (
        .clk       (clk),
        .reset     (reset),
        .inValid   (pixelInValid),
        .inReady   (pixelInReady),
        .point     (pixelIn),
        .payloadIn (pixelTagIn),
        .outValid  (pixelLocValid),
        .outReady  (pixelLocReady),
        .located   (pixelLocated),
        .payloadOut(pixelTagLoc)
    );

    barrierPixelStage pixelStage (
        .clk       (clk),
        .reset     (reset),
        .inValid   (pixelLocValid),
        .inReady   (pixelLocReady),
        .located   (pixelLocated),
        .tag       (pixelTagLoc),
        .readAddr  (readAddr),
        .readHealth(readHealth),
        .outValid  (pixelOutValid),
        .outReady  (pixelOutReady),
        .isBarrier (isBarrier),
        .rgb       (rgb),
        .last      (pixelOutLast)
    );

    ////////////////////
    // Laser path
    ////////////////////

    // Point of the laser now at the store; its pulse follows one edge later
    barrierLocator #(
        .payloadT    (barrierPkg::screenPointT),
        .blockSize   (blockSize),
        .barrierLeftX(barrierLeftX),
        .barrierTopY (barrierTopY),
        .barrierPitch(barrierPitch)
    ) laserLocator (
        .clk       (clk),
        .reset     (reset),
        .inValid   (laserValid),
        .inReady   (laserReady),
        .point     (laser),
        .payloadIn (laser),
        .outValid  (laserLocValid),
        .outReady  (laserLocReady),
        .located   (laserLocated),
        .payloadOut(laserHitPoint)
    );

    barrierHealthStore healthStore (
        .clk        (clk),
        .reset      (reset),
        .restart    (restart),
        .damageValid(laserLocValid),
        .damageReady(laserLocReady),
        .damageAddr (laserLocated),
        .laserHit   (laserHit),
        .laserMiss  (laserMiss),
        .readAddr   (readAddr),
        .readHealth (readHealth)
    );

endmodule

`default_nettype wire

// File: tb/barrierTb_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module barrierTb_assertions (
    input wire logic                    clk,
    input wire logic                    reset,
    input wire logic                    pixelOutValid,
    input wire logic                    pixelOutReady,
    input wire logic                    isBarrier,
    input wire barrierPkg::colorT       rgb,
    input wire logic                    pixelOutLast,
    input wire logic                    laserLocValid,
    input wire logic                    laserLocReady,
    input wire barrierPkg::locatedT     laserLocated,
    input wire barrierPkg::screenPointT laserHitPoint,
    input wire logic                    laserHit,
    input wire logic                    laserMiss
);

    // Failures seen so far, read by the testbench summary
    int failCount = 0;

    ////////////////////
    // Handshake
    ////////////////////

    // Pixel result frozen while the sink stalls
    pixelHold: assert property (@(posedge clk) disable iff (reset)
        pixelOutValid && !pixelOutReady
            |=> pixelOutValid && $stable({isBarrier, rgb, pixelOutLast}))
        else begin
            $error("pixel result changed or vanished while stalled");
            failCount++;
        end

    // Located laser waits at the store during restart
    laserHold: assert property (@(posedge clk) disable iff (reset)
        laserLocValid && !laserLocReady
            |=> laserLocValid && $stable(laserLocated) && $stable(laserHitPoint))
        else begin
            $error("located laser changed or vanished while the store refused it");
            failCount++;
        end

    // Nothing valid comes out of reset
    resetQuiet: assert property (@(posedge clk)
        reset |=> !pixelOutValid && !laserLocValid && !laserHit && !laserMiss)
        else begin
            $error("an output valid or pulse was high during reset");
            failCount++;
        end

    ////////////////////
    // Hit and colour
    ////////////////////

    hitXorMiss: assert property (@(posedge clk) disable iff (reset)
        !(laserHit && laserMiss))
        else begin
            $error("laser hit and miss pulsed together");
            failCount++;
        end

    // Zero top bit, living health, fixed tint; black off the barriers
    colourRule: assert property (@(posedge clk) disable iff (reset)
        pixelOutValid |-> (isBarrier
            ? (rgb[7] == 1'b0 && rgb[6:4] != 3'd0 && rgb[3:0] == barrierPkg::barrierTint)
            : (rgb == '0)))
        else begin
            $error("pixel colour breaks the health colour rule");
            failCount++;
        end

endmodule

`default_nettype wire

// File: tb/barrierTb.sv
`timescale 1ns/1ns
`default_nettype none

module barrierTb;

    // Geometry handed to the DUT and the model
    localparam int blockSize    = 8;
    localparam int barrierLeftX = 96;
    localparam int barrierTopY  = 400;
    localparam int barrierPitch = 128;
    localparam int clkPeriod    = 8;

    // Run length bound for the watchdog
    localparam int scanPixels     = 4 * 6 * 6;
    localparam int randomPixels   = 200;
    localparam int pixelTotal     = 3 * scanPixels + 8 + randomPixels;
    localparam int laserCount     = 12;
    localparam int watchdogCycles = 4 * pixelTotal + 16 * laserCount + 200;

    typedef struct packed {
        logic              isBarrier;
        barrierPkg::colorT rgb;
        logic              last;
    } pixelResultT;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    restart;
    logic                    pixelInValid;
    logic                    pixelInReady;
    barrierPkg::screenPointT pixelIn;
    logic                    pixelInLast;
    logic                    pixelOutValid;
    logic                    pixelOutReady;
    logic                    isBarrier;
    barrierPkg::colorT       rgb;
    logic                    pixelOutLast;
    logic                    laserValid;
    logic                    laserReady;
    barrierPkg::screenPointT laser;
    logic                    laserHit;
    logic                    laserMiss;
    barrierPkg::screenPointT laserHitPoint;

    // Model state and bookkeeping
    int          modelHealth [4][4][4];
    pixelResultT expectQ [$];
    string       testName = "reset";
    int          checkCount = 0;
    int          errorCount = 0;
    int          errorsAtStart = 0;
    int          testsRun = 0;
    int          testsFailed = 0;
    logic        sendDone;

    barrierDisplayTop #(
        .blockSize   (blockSize),
        .barrierLeftX(barrierLeftX),
        .barrierTopY (barrierTopY),
        .barrierPitch(barrierPitch)
    ) i_dut (
        .clk          (clk),
        .reset        (reset),
        .restart      (restart),
        .pixelInValid (pixelInValid),
        .pixelInReady (pixelInReady),
        .pixelIn      (pixelIn),
        .pixelInLast  (pixelInLast),
        .pixelOutValid(pixelOutValid),
        .pixelOutReady(pixelOutReady),
        .isBarrier    (isBarrier),
        .rgb          (rgb),
        .pixelOutLast (pixelOutLast),
        .laserValid   (laserValid),
        .laserReady   (laserReady),
        .laser        (laser),
        .laserHit     (laserHit),
        .laserMiss    (laserMiss),
        .laserHitPoint(laserHitPoint)
    );

    bind barrierDisplayTop barrierTb_assertions assertChecks (
        .clk          (clk),
        .reset        (reset),
        .pixelOutValid(pixelOutValid),
        .pixelOutReady(pixelOutReady),
        .isBarrier    (isBarrier),
        .rgb          (rgb),
        .pixelOutLast (pixelOutLast),
        .laserLocValid(laserLocValid),
        .laserLocReady(laserLocReady),
        .laserLocated (laserLocated),
        .laserHitPoint(laserHitPoint),
        .laserHit     (laserHit),
        .laserMiss    (laserMiss)
    );

    initial begin
        forever #(clkPeriod / 2) clk = !clk;
    end

    ////////////////////
    // Reference model
    ////////////////////

    // Arch cut-out with outer legs open in row 3 and inner columns in rows 2 and 3
    function automatic int archHealth(input int col, input int row);
        if (col == 0 || col == 3) begin
            return (row == 3) ? 0 : 3;
        end
        return (row >= 2) ? 0 : 3;
    endfunction

    function automatic void initModel();
        for (int b = 0; b < 4; b++)
            for (int c = 0; c < 4; c++)
                for (int r = 0; r < 4; r++)
                    modelHealth[b][c][r] = archHealth(c, r);
    endfunction

    // Finds barrier, column and row of a point or returns false off every barrier
    function automatic logic locatePoint(input int x, input int y,
                                         output int b, output int c, output int r);
        int offset;
        b = 0;
        c = 0;
        r = 0;
        if (y < barrierTopY || y >= barrierTopY + 4 * blockSize || x < barrierLeftX) begin
            return 1'b0;
        end
        offset = x - barrierLeftX;
        b = offset / barrierPitch;
        if (b >= 4 || offset % barrierPitch >= 4 * blockSize) begin
            return 1'b0;
        end
        c = (offset % barrierPitch) / blockSize;
        r = (y - barrierTopY) / blockSize;
        return 1'b1;
    endfunction

    function automatic pixelResultT expectedPixel(input int x, input int y, input logic last);
        pixelResultT res;
        int          b;
        int          c;
        int          r;
        res = '0;
        res.last = last;
        if (locatePoint(x, y, b, c, r) && modelHealth[b][c][r] > 0) begin
            res.isBarrier = 1'b1;
            res.rgb = {1'b0, 3'(modelHealth[b][c][r]), barrierPkg::barrierTint};
        end
        return res;
    endfunction

    ////////////////////
    // Checks
    ////////////////////

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            $display("error in test %s: %s expected %0h actual %0h",
                     testName, what, expected, actual);
            errorCount++;
        end
    endtask

    // Pixel results in order against the queued expectations
    always @(posedge clk) begin
        pixelResultT exp;
        if (!reset && pixelOutValid && pixelOutReady) begin
            if (expectQ.size() == 0) begin
                $display("test %s: a pixel result came out with no pixel in flight", testName);
                errorCount++;
            end else begin
                exp = expectQ.pop_front();
                checkValue("isBarrier", 32'(exp.isBarrier), 32'(isBarrier));
                checkValue("rgb", 32'(exp.rgb), 32'(rgb));
                checkValue("pixelOutLast", 32'(exp.last), 32'(pixelOutLast));
            end
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    // Starts just after a rising edge and returns on the accepting edge
    task automatic sendPixel(input int x, input int y, input logic lastFlag);
        pixelResultT exp;
        exp = expectedPixel(x, y, lastFlag);
        pixelInValid <= 1'b1;
        pixelIn.x    <= barrierPkg::coordT'(x);
        pixelIn.y    <= barrierPkg::coordT'(y);
        pixelInLast  <= lastFlag;
        @(posedge clk);
        while (!pixelInReady) @(posedge clk);
        expectQ.push_back(exp);
    endtask

    // Block centres over every barrier plus a ring of gap blocks
    task automatic scanBarriers();
        for (int b = 0; b < 4; b++)
            for (int r = -1; r <= 4; r++)
                for (int c = -1; c <= 4; c++)
                    sendPixel(barrierLeftX + barrierPitch * b + blockSize * c + 4,
                              barrierTopY + blockSize * r + 4, c == 4);
    endtask

    task automatic awaitLaser(input logic expHit, input int x, input int y);
        @(posedge clk);
        while (!(laserHit || laserMiss)) @(posedge clk);
        checkValue("laserHit", 32'(expHit), 32'(laserHit));
        checkValue("laserMiss", 32'(!expHit), 32'(laserMiss));
        checkValue("laserHitPoint", 32'({11'(x), 11'(y)}), 32'(laserHitPoint));
    endtask

    task automatic fireLaser(input int x, input int y);
        int   b;
        int   c;
        int   r;
        logic expHit;
        laserValid <= 1'b1;
        laser.x    <= barrierPkg::coordT'(x);
        laser.y    <= barrierPkg::coordT'(y);
        @(posedge clk);
        while (!laserReady) @(posedge clk);
        laserValid <= 1'b0;
        // Decrement rule on a living block
        expHit = locatePoint(x, y, b, c, r) && modelHealth[b][c][r] > 0;
        if (expHit) begin
            modelHealth[b][c][r]--;
        end
        awaitLaser(expHit, x, y);
    endtask

    task automatic startTest(input string name);
        testName = name;
        errorsAtStart = errorCount;
    endtask

    // Drain the pixel path and report
    task automatic endTest();
        pixelInValid <= 1'b0;
        @(posedge clk);
        while (expectQ.size() != 0) @(posedge clk);
        testsRun++;
        if (errorCount != errorsAtStart) begin
            testsFailed++;
        end
        $display("test %s done: %0d errors", testName, errorCount - errorsAtStart);
    endtask

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("watchdog expired after %0d cycles, the DUT stopped answering",
                 watchdogCycles);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h9bbf));
        reset         = 1'b1;
        restart       = 1'b0;
        pixelInValid  = 1'b0;
        pixelIn       = '0;
        pixelInLast   = 1'b0;
        pixelOutReady = 1'b1;
        laserValid    = 1'b0;
        laser         = '0;
        sendDone      = 1'b0;
        initModel();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        startTest("resetScan");
        scanBarriers();
        endTest();

        // Barrier 1, column 0, row 0
        startTest("laserHit");
        fireLaser(228, 404);
        sendPixel(228, 404, 1'b1);
        endTest();

        startTest("laserWearDown");
        repeat (3) fireLaser(228, 404);
        sendPixel(228, 404, 1'b0);
        sendPixel(231, 407, 1'b1);
        endTest();

        // Open sky, arch cut-out, gap right of barrier 3
        startTest("laserMiss");
        fireLaser(10, 300);
        fireLaser(364, 428);
        fireLaser(520, 404);
        scanBarriers();
        endTest();

        startTest("restart");
        fireLaser(100, 404);
        fireLaser(100, 404);
        fireLaser(508, 420);
        // Laser parked at the store while restart holds it off
        restart    <= 1'b1;
        laserValid <= 1'b1;
        laser.x    <= barrierPkg::coordT'(10);
        laser.y    <= barrierPkg::coordT'(300);
        @(posedge clk);
        laserValid <= 1'b0;
        @(posedge clk);
        // Locator full and store refusing
        checkValue("laserReady", 32'(1'b0), 32'(laserReady));
        @(posedge clk);
        restart <= 1'b0;
        initModel();
        awaitLaser(1'b0, 10, 300);
        scanBarriers();
        endTest();

        startTest("stallOrder");
        fork
            begin
                for (int i = 0; i < randomPixels; i++) begin
                    sendPixel(64 + $urandom % 560, 384 + $urandom % 64, ($urandom % 8) == 0);
                end
                pixelInValid <= 1'b0;
                sendDone = 1'b1;
            end
            begin
                // Random back-pressure until everything is out
                while (!sendDone || expectQ.size() != 0) begin
                    @(posedge clk);
                    pixelOutReady <= ($urandom % 3) != 0;
                end
                pixelOutReady <= 1'b1;
            end
        join
        endTest();

        repeat (4) @(posedge clk);
        $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 testsRun, testsFailed, checkCount, errorCount,
                 i_dut.assertChecks.failCount);
        if (errorCount == 0 && i_dut.assertChecks.failCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
src/barrierPkg.sv
src/barrierLocator.sv
src/barrierHealthStore.sv
src/barrierPixelStage.sv
src/barrierDisplayTop.sv
tb/barrierTb_assertions.sv
tb/barrierTb.sv

// File: Bender.yml
package:
  name: barrier_display

sources:
  # Design, package first
  - src/barrierPkg.sv
  - src/barrierLocator.sv
  - src/barrierHealthStore.sv
  - src/barrierPixelStage.sv
  - src/barrierDisplayTop.sv

  # Testbench, top module barrierTb
  - target: simulation
    files:
      - tb/barrierTb_assertions.sv
      - tb/barrierTb.sv
